// ==== qspi_rom_reader.f ====
src/qspi_pkg.sv
src/qspi_ctrl_if.sv
src/apb_regs.sv
src/qspi_sequencer.sv
src/qspi_bit_counter.sv
src/qspi_shifter.sv
src/qspi_rom_reader.sv
verification/qspi_flash_model.sv
verification/tb_qspi_rom_reader.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module tb_qspi_rom_reader \
    -f qspi_rom_reader.f \
    -o tb_qspi_rom_reader

out=$(./obj_dir/tb_qspi_rom_reader)
printf '%s\n' "$out"
echo "$out" | grep -qx "All checks passed"

// ==== src/apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_regs import qspi_pkg::*; (
    input  logic        clk,
    input  logic        nreset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    qspi_ctrl_if.regs   ctrl
);

    logic        access;
    logic        busy_any;
    logic        mapped;
    logic        start_q;
    logic        done_sticky;
    logic [23:0] addr_q;
    logic [31:0] data_q;

    assign access   = psel && penable;
    assign busy_any = ctrl.busy || start_q;   // covers the cycle before busy rises.
    assign mapped   = (paddr == reg_addr) || (paddr == reg_ctrl) ||
                      (paddr == reg_status) || (paddr == reg_data);

    // a data read during a fetch holds the bus until the word arrives.
    assign pready  = !(access && !pwrite && (paddr == reg_data) && busy_any);
    assign pslverr = access && (!mapped || (pwrite && (paddr == reg_ctrl) && busy_any));

    assign ctrl.start   = start_q;
    assign ctrl.address = addr_q;

    always_comb begin
        case (paddr)
            reg_addr:   prdata = {8'h00, addr_q};
            reg_status: prdata = {29'd0, ctrl.ready, done_sticky, ctrl.busy};
            reg_data:   prdata = ctrl.done ? ctrl.rdata : data_q;  // bypass on the done cycle.
            default:    prdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            start_q     <= 1'b0;
            done_sticky <= 1'b0;
            addr_q      <= 24'd0;
        end else begin
            start_q <= access && pwrite && (paddr == reg_ctrl) && pwdata[0] &&
                       !busy_any && ctrl.ready;
            if (access && pwrite && (paddr == reg_addr))
                addr_q <= pwdata[23:0];
            if (start_q)
                done_sticky <= 1'b0;
            else if (ctrl.done)
                done_sticky <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.done)
            data_q <= ctrl.rdata;
    end

    // a fetch is only requested from an idle sequencer that is in quad mode.
    a_start_when_ready: assert property (
        @(posedge clk) disable iff (!nreset)
        ctrl.start |-> (ctrl.ready && !ctrl.busy)
    );

endmodule

`default_nettype wire

// ==== src/qspi_bit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module qspi_bit_counter import qspi_pkg::*; (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 load,
    input  logic [cnt_width-1:0] load_value,
    output logic                 zero
);

    logic [cnt_width-1:0] count;

    // a load of n raises zero in the n-th cycle after it.
    always_ff @(posedge clk) begin
        if (!nreset) begin
            count <= '0;
            zero  <= 1'b1;
        end else if (load) begin
            count <= load_value - 1'b1;
            zero  <= (load_value == cnt_width'(1));
        end else if (count != '0) begin
            count <= count - 1'b1;
            zero  <= (count == cnt_width'(1));
        end
    end

    // a new phase may only begin once the running one has ended.
    a_load_at_zero: assert property (
        @(posedge clk) disable iff (!nreset)
        load |-> zero
    );

endmodule

`default_nettype wire

// ==== src/qspi_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// control link between the APB register block and the read sequencer.
interface qspi_ctrl_if;

    logic        start;     // one-cycle request, only while ready and not busy.
    logic [23:0] address;   // byte address of the word to fetch.
    logic        busy;
    logic        ready;     // high once the ROM has been switched to quad mode.
    logic        done;      // one-cycle pulse, rdata is valid with it.
    logic [31:0] rdata;

    modport regs (
        output start,
        output address,
        input  busy,
        input  ready,
        input  done,
        input  rdata
    );

    modport seq (
        input  start,
        input  address,
        output busy,
        output ready,
        output done,
        output rdata
    );

endinterface

`default_nettype wire

// ==== src/qspi_pkg.sv ====
`default_nettype none

package qspi_pkg;

    // ROM commands.
    localparam logic [7:0] cmd_enter_qpi = 8'h38;   // sent on lane 0 only.
    localparam logic [7:0] cmd_fast_read = 8'h0B;

    // phase lengths in clk cycles.
    localparam int send_cycles  = 8;
    localparam int dummy_cycles = 2;
    localparam int read_nibbles = 8;

    localparam int cnt_width = 4;   // must hold the longest phase.

    // APB register offsets.
    localparam logic [3:0] reg_addr   = 4'h0;
    localparam logic [3:0] reg_ctrl   = 4'h4;
    localparam logic [3:0] reg_status = 4'h8;
    localparam logic [3:0] reg_data   = 4'hC;

endpackage

`default_nettype wire

// ==== src/qspi_rom_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module qspi_rom_reader import qspi_pkg::*; (
    input  logic        clk,
    input  logic        nreset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        rom_sck,
    output logic [3:0]  rom_sio_out,
    input  logic [3:0]  rom_sio_in,
    output logic        rom_sio_oe0,
    output logic        rom_sio_oe123,
    output logic        rom_ncs
);

    logic                 cnt_load;
    logic [cnt_width-1:0] cnt_value;
    logic                 cnt_zero;
    logic                 load_init;
    logic                 load_read;
    logic                 shift;
    logic                 capture;

    qspi_ctrl_if ctrl_bus ();

    apb_regs u_regs (
        .clk     (clk),
        .nreset  (nreset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctrl    (ctrl_bus.regs)
    );

    qspi_sequencer u_seq (
        .clk           (clk),
        .nreset        (nreset),
        .ctrl          (ctrl_bus.seq),
        .cnt_load      (cnt_load),
        .cnt_value     (cnt_value),
        .cnt_zero      (cnt_zero),
        .load_init     (load_init),
        .load_read     (load_read),
        .shift         (shift),
        .capture       (capture),
        .rom_ncs       (rom_ncs),
        .rom_sio_oe0   (rom_sio_oe0),
        .rom_sio_oe123 (rom_sio_oe123)
    );

    qspi_bit_counter u_cnt (
        .clk        (clk),
        .nreset     (nreset),
        .load       (cnt_load),
        .load_value (cnt_value),
        .zero       (cnt_zero)
    );

    // the captured word goes straight onto the control link.
    qspi_shifter u_shift (
        .clk         (clk),
        .nreset      (nreset),
        .load_init   (load_init),
        .load_read   (load_read),
        .shift       (shift),
        .capture     (capture),
        .address     (ctrl_bus.address),
        .ncs         (rom_ncs),
        .rom_sck     (rom_sck),
        .rom_sio_out (rom_sio_out),
        .rom_sio_in  (rom_sio_in),
        .rdata       (ctrl_bus.rdata)
    );

endmodule

`default_nettype wire

// ==== src/qspi_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module qspi_sequencer import qspi_pkg::*; (
    input  logic                 clk,
    input  logic                 nreset,
    qspi_ctrl_if.seq             ctrl,
    output logic                 cnt_load,
    output logic [cnt_width-1:0] cnt_value,
    input  logic                 cnt_zero,
    output logic                 load_init,
    output logic                 load_read,
    output logic                 shift,
    output logic                 capture,
    output logic                 rom_ncs,
    output logic                 rom_sio_oe0,
    output logic                 rom_sio_oe123
);

    logic st_init, st_idle, st_send, st_turn, st_dummy, st_read;

    assign load_init = st_init;
    assign load_read = st_idle && ctrl.start;
    assign shift     = st_send;
    assign capture   = st_read;   // sampled on the falling edge in the shifter.

    // every phase but the last one of a read hands over to a new counter load.
    assign cnt_load = st_init || load_read ||
                      (cnt_zero && ((st_send && ctrl.ready) || st_turn || st_dummy));

    always_comb begin
        if (st_turn)
            cnt_value = cnt_width'(dummy_cycles);
        else if (st_dummy)
            cnt_value = cnt_width'(read_nibbles);
        else if (st_send)
            cnt_value = cnt_width'(1);   // one turnaround cycle.
        else
            cnt_value = cnt_width'(send_cycles);
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            {st_init, st_idle, st_send, st_turn, st_dummy, st_read} <= 6'b100000;
            rom_ncs       <= 1'b1;
            rom_sio_oe0   <= 1'b1;
            rom_sio_oe123 <= 1'b0;
            ctrl.busy     <= 1'b0;
            ctrl.ready    <= 1'b0;
            ctrl.done     <= 1'b0;
        end else begin
            ctrl.done <= 1'b0;
            if (st_init) begin
                st_init <= 1'b0;
                st_send <= 1'b1;
                rom_ncs <= 1'b0;
            end
            if (load_read) begin
                st_idle       <= 1'b0;
                st_send       <= 1'b1;
                rom_ncs       <= 1'b0;
                rom_sio_oe123 <= 1'b1;
                ctrl.busy     <= 1'b1;
            end
            if (st_send && cnt_zero) begin
                st_send <= 1'b0;
                if (!ctrl.ready) begin   // the quad-mode command is complete.
                    st_idle    <= 1'b1;
                    rom_ncs    <= 1'b1;
                    ctrl.ready <= 1'b1;
                end else begin
                    st_turn       <= 1'b1;
                    rom_sio_oe0   <= 1'b0;
                    rom_sio_oe123 <= 1'b0;
                end
            end
            if (st_turn && cnt_zero) begin
                st_turn  <= 1'b0;
                st_dummy <= 1'b1;
            end
            if (st_dummy && cnt_zero) begin
                st_dummy <= 1'b0;
                st_read  <= 1'b1;
            end
            if (st_read && cnt_zero) begin
                st_read     <= 1'b0;
                st_idle     <= 1'b1;
                rom_ncs     <= 1'b1;
                rom_sio_oe0 <= 1'b1;
                ctrl.busy   <= 1'b0;
                ctrl.done   <= 1'b1;
            end
        end
    end

    a_oe_with_ncs: assert property (
        @(posedge clk) disable iff (!nreset)
        rom_ncs |-> !rom_sio_oe123
    );

    // exactly one state is active at any time.
    a_one_state: assert property (
        @(posedge clk) disable iff (!nreset)
        $onehot({st_init, st_idle, st_send, st_turn, st_dummy, st_read})
    );

endmodule

`default_nettype wire

// ==== src/qspi_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module qspi_shifter import qspi_pkg::*; (
    input  logic        clk,
    input  logic        nreset,
    input  logic        load_init,
    input  logic        load_read,
    input  logic        shift,
    input  logic        capture,
    input  logic [23:0] address,
    input  logic        ncs,
    output logic        rom_sck,
    output logic [3:0]  rom_sio_out,
    input  logic [3:0]  rom_sio_in,
    output logic [31:0] rdata
);

    logic [3:0][7:0] lanes;   // one byte per lane, msb goes out first.
    logic [31:0]     cap_sr;

    assign rom_sck = ncs ? 1'b0 : !clk;

    assign rom_sio_out = {lanes[3][7], lanes[2][7], lanes[1][7], lanes[0][7]};

    // lane k carries bit k of every nibble of command and address.
    always_ff @(posedge clk) begin
        if (!nreset) begin
            lanes <= '0;
        end else if (load_init) begin
            lanes    <= '0;
            lanes[0] <= cmd_enter_qpi;
        end else if (load_read) begin
            for (int k = 0; k < 4; k++) begin
                lanes[k] <= {cmd_fast_read[4+k], cmd_fast_read[k],
                             address[20+k], address[16+k], address[12+k],
                             address[8+k], address[4+k], address[k]};
            end
        end else if (shift) begin
            for (int k = 0; k < 4; k++) begin
                lanes[k] <= {lanes[k][6:0], 1'b0};
            end
        end
    end

    // the ROM drives on the falling sck edge, so sample half a cycle later.
    always_ff @(negedge clk) begin
        if (capture)
            cap_sr <= {cap_sr[27:0], rom_sio_in};
    end

    // first byte received is the lowest byte of the word.
    assign rdata = {cap_sr[7:0], cap_sr[15:8], cap_sr[23:16], cap_sr[31:24]};

endmodule

`default_nettype wire

// ==== verification/qspi_flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// quad-SPI ROM that knows only the quad-mode entry and the fast read.
module qspi_flash_model (
    input  logic       sck,
    input  logic       ncs,
    input  logic [3:0] sio_in,
    output logic [3:0] sio_out,
    output int         fault_count
);

    logic        quad_mode = 1'b0;
    logic [31:0] cmd_sr = 32'd0;
    logic [23:0] rd_addr = 24'd0;
    logic [7:0]  data_byte = 8'd0;
    logic [3:0]  drive = 4'd0;
    int          edges = 0;
    int          nib = 0;
    int          faults = 0;

    assign sio_out     = drive;
    assign fault_count = faults;

    // every byte is the xor of its three address bytes and 0x5a.
    function automatic logic [7:0] rom_byte(input logic [23:0] a);
        return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
    endfunction

    initial begin
        forever begin
            @(negedge ncs);
            edges  = 0;
            cmd_sr = 32'd0;
            while (ncs === 1'b0) begin
                @(posedge sck or negedge sck or posedge ncs);
                if (ncs === 1'b0 && sck === 1'b1) begin
                    if (edges < 8)   // one bit per clock before quad mode, a nibble after.
                        cmd_sr = quad_mode ? {cmd_sr[27:0], sio_in} : {cmd_sr[30:0], sio_in[0]};
                    edges = edges + 1;
                    if (quad_mode && edges == 8) begin
                        rd_addr = cmd_sr[23:0];
                        if (cmd_sr[31:24] != 8'h0B) begin
                            $display("flash model: unknown command %h at %0t", cmd_sr[31:24], $time);
                            faults = faults + 1;
                        end
                    end
                end else if (ncs === 1'b0 && sck === 1'b0) begin
                    // turnaround and two dummy clocks end after the 11th rising edge.
                    if (quad_mode && edges >= 11 && edges < 19) begin
                        nib       = edges - 11;
                        data_byte = rom_byte(rd_addr + 24'(nib >> 1));
                        drive     = nib[0] ? data_byte[3:0] : data_byte[7:4];
                    end
                end
            end
            if (!quad_mode) begin
                if (edges != 8 || cmd_sr[7:0] != 8'h38) begin
                    $display("flash model: quad-mode command 0x38 was not received on lane 0");
                    faults = faults + 1;
                end else begin
                    quad_mode = 1'b1;
                end
            end else if (edges != 19) begin
                $display("flash model: read lasted %0d clocks instead of 19", edges);
                faults = faults + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_qspi_rom_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_qspi_rom_reader import qspi_pkg::*; ();

    localparam int stall_limit = 100;   // clock cycles per APB access.
    localparam int poll_limit  = 50;    // status reads per wait.

    logic        clk = 1'b0;
    logic        nreset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        rom_sck;
    logic [3:0]  sio_to_rom;
    logic [3:0]  sio_from_rom;
    logic        rom_sio_oe0;
    logic        rom_sio_oe123;
    logic        rom_ncs;
    int          flash_faults;
    int          error_count = 0;
    int          check_count = 0;
    integer      seed;

    logic [31:0] got_q[$];
    logic [31:0] exp_q[$];
    string       what_q[$];

    qspi_rom_reader u_dut (
        .clk           (clk),
        .nreset        (nreset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .rom_sck       (rom_sck),
        .rom_sio_out   (sio_to_rom),
        .rom_sio_in    (sio_from_rom),
        .rom_sio_oe0   (rom_sio_oe0),
        .rom_sio_oe123 (rom_sio_oe123),
        .rom_ncs       (rom_ncs)
    );

    qspi_flash_model u_flash (
        .sck         (rom_sck),
        .ncs         (rom_ncs),
        .sio_in      (sio_to_rom),
        .sio_out     (sio_from_rom),
        .fault_count (flash_faults)
    );

    always #50 clk = ~clk;

    // bytes a to a+3 in little-endian order, each from its own full address.
    function automatic logic [31:0] expected_word(input logic [23:0] a);
        logic [31:0] w;
        logic [23:0] b;
        w = 32'd0;
        for (int j = 0; j < 4; j++) begin
            b = a + 24'(j);
            w[8*j +: 8] = b[7:0] ^ b[15:8] ^ b[23:16] ^ 8'h5a;
        end
        return w;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        what_q.push_back(what);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    always @(negedge clk) begin
        while (got_q.size() > 0)
            check_value(what_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $finish;
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err, output int stalls);
        stalls = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);   // pready at mid-cycle is what the next edge sees.
        while (!pready && stalls < stall_limit) begin
            stalls++;
            @(negedge clk);
        end
        if (!pready) begin
            abort_run($sformatf("APB access to offset %h was never completed", addr));
        end else begin
            rdata = prdata;
            err   = pslverr;
            @(posedge clk);
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic poll_status(input int bit_index, input string what);
        logic [31:0] status;
        logic        err;
        int          stalls;
        int          polls;
        polls = 0;
        apb_access(1'b0, reg_status, 32'd0, status, err, stalls);
        while (!status[bit_index] && polls < poll_limit) begin
            polls++;
            apb_access(1'b0, reg_status, 32'd0, status, err, stalls);
        end
        if (!status[bit_index])
            abort_run($sformatf("status %s bit never rose", what));
    endtask

    task automatic start_read(input logic [23:0] a);
        logic [31:0] unused;
        logic        err;
        int          stalls;
        apb_access(1'b1, reg_addr, {8'h00, a}, unused, err, stalls);
        expect_value("address write pslverr", {31'd0, err}, 32'd0);
        apb_access(1'b1, reg_ctrl, 32'd1, unused, err, stalls);
        expect_value("start write pslverr", {31'd0, err}, 32'd0);
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] previous;
        logic [23:0] a;
        logic        err;
        int          stalls;
        seed    = 32'hcf906d98;
        nreset  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 4'd0;
        pwdata  = 32'd0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        expect_value("ncs in reset", {31'd0, rom_ncs}, 32'd1);
        expect_value("lane 0 enable in reset", {31'd0, rom_sio_oe0}, 32'd1);
        expect_value("lane 1-3 enable in reset", {31'd0, rom_sio_oe123}, 32'd0);
        @(posedge clk);
        nreset <= 1'b1;

        poll_status(2, "ready");

        previous = 32'd0;
        for (int i = 0; i < 20; i++) begin
            a = 24'($random(seed));
            start_read(a);
            poll_status(1, "done");
            apb_access(1'b0, reg_data, 32'd0, data, err, stalls);
            expect_value($sformatf("polled read at %h", a), data, expected_word(a));
            previous = data;
        end

        // no polling, so the data read has to hold the bus.
        a = 24'($random(seed));
        start_read(a);
        apb_access(1'b0, reg_data, 32'd0, data, err, stalls);
        expect_value("data read stalled", (stalls > 0) ? 32'd1 : 32'd0, 32'd1);
        expect_value($sformatf("stalled read at %h", a), data, expected_word(a));
        expect_value("stalled read is a new word", (data !== previous) ? 32'd1 : 32'd0, 32'd1);

        a = 24'hfffffe;   // the word wraps at the top of the address space.
        start_read(a);
        apb_access(1'b1, reg_ctrl, 32'd1, data, err, stalls);
        expect_value("start while busy pslverr", {31'd0, err}, 32'd1);
        apb_access(1'b0, reg_data, 32'd0, data, err, stalls);
        expect_value("read after refused start", data, expected_word(a));

        apb_access(1'b1, reg_addr, 32'ha5123456, data, err, stalls);
        apb_access(1'b0, reg_addr, 32'd0, data, err, stalls);
        expect_value("address readback", data, 32'h00123456);
        apb_access(1'b0, 4'h2, 32'd0, data, err, stalls);
        expect_value("unmapped read pslverr", {31'd0, err}, 32'd1);
        expect_value("unmapped read data", data, 32'd0);
        apb_access(1'b1, 4'h6, 32'hffffffff, data, err, stalls);
        expect_value("unmapped write pslverr", {31'd0, err}, 32'd1);

        @(negedge clk);
        @(negedge clk);
        $display("checks: %0d, errors: %0d, flash model faults: %0d",
                 check_count, error_count, flash_faults);
        if (error_count == 0 && flash_faults == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
